//--- bench/tb_clock_gen.sv
// testbench clock and reset generator
`default_nettype none
`timescale 1ns/1ns

module tb_clock_gen (
   output logic clk,
   output logic rst_n
);

   localparam int PERIOD       = 8;
   localparam int RESET_CYCLES = 8;

   initial
   begin
      clk = 1'b0;
      forever #(PERIOD/2) clk = ~clk;
   end

   // rising edges at 4, 12, ...; release 1 ns after the eighth one
   initial
   begin
      rst_n = 1'b0;
      #(RESET_CYCLES*PERIOD - PERIOD/2 + 1);
      rst_n = 1'b1;
   end

endmodule

`default_nettype wire

//--- bench/tb_exu_alu.sv
// table-driven testbench for the execute stage, with a reference model for random rows
`default_nettype none
`timescale 1ns/1ns
`include "exu_settings.svh"

module tb_exu_alu;

   import exu_pkg::*;

   localparam int CLK_PERIOD = 8;
   localparam int MAX_ROWS   = 128;

   typedef struct packed {
      alu_op_t                  op;
      logic [`EXU_DATA_W-1:0]   a;
      logic [`EXU_DATA_W-1:0]   b;
      logic [`EXU_PC_W-1:0]     pc;
      logic [`EXU_BRIMM_W-1:0]  imm;
      logic                     pt;
      logic                     pnt;
      logic [`EXU_HIST_W-1:0]   hist;
      logic                     fux;
      logic                     flr;
      logic                     valid;
      logic                     en;
      logic [`EXU_DATA_W-1:0]   exp_res;
      logic [`EXU_PC_W-1:0]     exp_path;
      logic                     exp_fu;
      logic                     exp_ff;
      logic                     exp_misp;
      logic                     exp_pc_ok;
      logic                     exp_taken;
      logic [`EXU_HIST_W-1:0]   exp_hist;
   } row_t;

   logic clk;
   logic rst_n;
   logic enable;
   logic valid_in;
   alu_op_t op;
   logic [`EXU_DATA_W-1:0]  a_in;
   logic [`EXU_DATA_W-1:0]  b_in;
   logic [`EXU_PC_W-1:0]    pc_in;
   logic [`EXU_BRIMM_W-1:0] brimm_in;
   logic predict_t;
   logic predict_nt;
   logic [`EXU_HIST_W-1:0]  hist_in;
   logic flush_upper_x;
   logic flush_lower_r;
   logic [`EXU_DATA_W-1:0]  result_ff;
   logic [`EXU_PC_W-1:0]    pc_ff;
   logic flush_upper_out;
   logic flush_final_out;
   logic [`EXU_PC_W-1:0]    flush_path_out;
   logic pred_correct_out;
   logic misp_out;
   logic ataken_out;
   logic [`EXU_HIST_W-1:0]  hist_out;

   row_t rows [0:MAX_ROWS-1];
   int   n_rows = 0;
   int   edge_count = 0;
   logic [`EXU_DATA_W-1:0] exp_result_ff;
   logic [`EXU_PC_W-1:0]   exp_pc_ff;

   tb_clock_gen u_clock_gen (
      .clk   (clk),
      .rst_n (rst_n)
   );

   exu_alu_ctl i_dut (
      .clk              (clk),
      .rst_n            (rst_n),
      .enable           (enable),
      .valid_in         (valid_in),
      .op               (op),
      .a_in             (a_in),
      .b_in             (b_in),
      .pc_in            (pc_in),
      .brimm_in         (brimm_in),
      .predict_t        (predict_t),
      .predict_nt       (predict_nt),
      .hist_in          (hist_in),
      .flush_upper_x    (flush_upper_x),
      .flush_lower_r    (flush_lower_r),
      .result_ff        (result_ff),
      .pc_ff            (pc_ff),
      .flush_upper_out  (flush_upper_out),
      .flush_final_out  (flush_final_out),
      .flush_path_out   (flush_path_out),
      .pred_correct_out (pred_correct_out),
      .misp_out         (misp_out),
      .ataken_out       (ataken_out),
      .hist_out         (hist_out)
   );

   // counted with a nonblocking update, so a poll at the edge still sees the old count
   always @(posedge clk)
      edge_count <= edge_count + 1;

   task automatic fail_run;
      $display("Result: FAILED");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp)
      else
      begin
         $display("mismatch at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
         fail_run();
      end
   endtask

   // returns 1 ns after the next rising edge
   task automatic wait_cycle;
      int target;
      int polls;
      target = edge_count + 1;
      polls  = 0;
      while (edge_count < target && polls < 4*CLK_PERIOD)
      begin
         #1;
         polls++;
      end
      if (edge_count < target)
      begin
         $display("timeout: no rising clock edge within %0d ns", polls);
         fail_run();
      end
   endtask

   function automatic logic [`EXU_PC_W-1:0] offset_target(input logic [`EXU_PC_W-1:0] pc,
                                                          input logic [`EXU_BRIMM_W-1:0] imm);
      return pc + {{(`EXU_PC_W-`EXU_BRIMM_W){imm[`EXU_BRIMM_W-1]}}, imm};
   endfunction

   function automatic logic [31:0] model_result(input alu_op_t f, input logic [31:0] a,
                                                input logic [31:0] b, input logic [30:0] pc,
                                                input logic [11:0] imm);
      case (f)
         op_add:  return a + b;
         op_sub:  return a - b;
         op_and:  return a & b;
         op_or:   return a | b;
         op_xor:  return a ^ b;
         op_sll:  return a << b[4:0];
         op_srl:  return a >> b[4:0];
         op_sra:  return $unsigned($signed(a) >>> b[4:0]);
         op_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         op_sltu: return (a < b) ? 32'd1 : 32'd0;
         op_jal:  return {offset_target(pc, imm), 1'b0};
         // branches leave a - b in the result
         default: return a - b;
      endcase
   endfunction

   function automatic logic model_taken(input alu_op_t f, input logic [31:0] a,
                                        input logic [31:0] b);
      case (f)
         op_jal:  return 1'b1;
         op_beq:  return a == b;
         op_bne:  return a != b;
         op_blt:  return $signed(a) < $signed(b);
         op_bltu: return a < b;
         op_bge:  return !($signed(a) < $signed(b));
         op_bgeu: return !(a < b);
         default: return 1'b0;
      endcase
   endfunction

   function automatic logic [1:0] hist_rule(input logic [1:0] h, input logic t);
      case ({h, t})
         3'b000:  return 2'b01;
         3'b010:  return 2'b01;
         3'b100:  return 2'b00;
         3'b110:  return 2'b10;
         3'b001:  return 2'b10;
         3'b011:  return 2'b00;
         3'b101:  return 2'b11;
         default: return 2'b11;
      endcase
   endfunction

   task automatic add_row(input alu_op_t f, input logic [31:0] a, input logic [31:0] b,
                          input logic [30:0] pc, input logic [11:0] imm, input logic pt,
                          input logic pnt, input logic [1:0] hist, input logic fux,
                          input logic flr, input logic valid, input logic en,
                          input logic [31:0] exp_res);
      row_t r;
      logic taken;
      logic misp;
      logic redirect;
      logic [31:0] sum;
      taken    = model_taken(f, a, b);
      misp     = (pt & ~taken) | (pnt & taken);
      redirect = ((f == op_jal) | misp) & valid & ~fux;
      sum      = a + b;
      r = '{f, a, b, pc, imm, pt, pnt, hist, fux, flr, valid, en, exp_res,
            (f == op_jal) ? sum[31:1] : offset_target(pc, imm),
            redirect & ~flr, redirect | flr, misp & ~fux & ~flr,
            valid & (f != op_jal) & ((pt & taken) | (pnt & ~taken)),
            taken, hist_rule(hist, taken)};
      if (n_rows >= MAX_ROWS)
      begin
         $display("stimulus table overflow at row %0d", n_rows);
         fail_run();
      end
      rows[n_rows] = r;
      n_rows++;
   endtask

   task automatic alu_row(input alu_op_t f, input logic [31:0] a, input logic [31:0] b,
                          input logic [31:0] exp_res);
      add_row(f, a, b, 31'h100 + n_rows, 12'd2, 0, 0, 2'b00, 0, 0, 1, 1, exp_res);
   endtask

   task automatic build_table;
      alu_op_t f;
      logic [31:0] a;
      logic [31:0] b;
      logic [30:0] pc;
      logic [11:0] imm;
      alu_row(op_add, 32'd5, 32'd7, 32'd12);
      alu_row(op_add, 32'hffff_ffff, 32'd1, 32'd0);
      alu_row(op_sub, 32'd3, 32'd5, 32'hffff_fffe);
      alu_row(op_and, 32'hf0f0_f0f0, 32'hff00_ff00, 32'hf000_f000);
      alu_row(op_or, 32'hf0f0_f0f0, 32'hff00_ff00, 32'hfff0_fff0);
      alu_row(op_xor, 32'hf0f0_f0f0, 32'hff00_ff00, 32'h0ff0_0ff0);
      alu_row(op_sll, 32'h8000_0001, 32'd0, 32'h8000_0001);
      alu_row(op_sll, 32'h0000_0003, 32'd31, 32'h8000_0000);
      // only the low five bits of b count as the shift amount
      alu_row(op_sll, 32'h1234_5678, 32'h0000_0024, 32'h2345_6780);
      alu_row(op_srl, 32'h8000_0000, 32'd31, 32'd1);
      alu_row(op_srl, 32'h8000_000f, 32'd0, 32'h8000_000f);
      alu_row(op_sra, 32'h8000_0000, 32'd31, 32'hffff_ffff);
      alu_row(op_sra, 32'hf000_0000, 32'd4, 32'hff00_0000);
      alu_row(op_sra, 32'h7000_0000, 32'd4, 32'h0700_0000);
      alu_row(op_slt, 32'hffff_ffff, 32'd1, 32'd1);
      alu_row(op_sltu, 32'hffff_ffff, 32'd1, 32'd0);
      alu_row(op_slt, 32'd1, 32'hffff_ffff, 32'd0);
      alu_row(op_sltu, 32'd1, 32'hffff_ffff, 32'd1);
      // six branches, both predictions, one equal and one mixed-sign operand pair
      for (int k = 0; k < 6; k++)
         for (int p = 0; p < 2; p++)
            for (int s = 0; s < 2; s++)
            begin
               f  = alu_op_t'(int'(op_beq) + k);
               a  = s ? 32'hffff_fffd : 32'd5;
               b  = s ? 32'd2 : 32'd5;
               pc = 31'h400 + n_rows;
               add_row(f, a, b, pc, 12'hff0, p, !p, 2'b01, 0, 0, 1, 1,
                       model_result(f, a, b, pc, 12'hff0));
            end
      // jal links pc plus 2 and pc plus 4, even when predicted taken
      add_row(op_jal, 32'h1000, 32'h24, 31'h100, 12'd1, 1, 0, 2'b00, 0, 0, 1, 1, 32'h202);
      add_row(op_jal, 32'h2001, 32'h7, 31'h180, 12'd2, 0, 0, 2'b11, 0, 0, 1, 1, 32'h304);
      // mispredicted beq, then the same with each flush input
      add_row(op_beq, 32'd1, 32'd2, 31'h500, 12'd8, 1, 0, 2'b10, 0, 0, 1, 1, 32'hffff_ffff);
      add_row(op_beq, 32'd1, 32'd2, 31'h501, 12'd8, 1, 0, 2'b10, 1, 0, 1, 1, 32'hffff_ffff);
      add_row(op_beq, 32'd1, 32'd2, 31'h502, 12'd8, 1, 0, 2'b10, 0, 1, 0, 1, 32'hffff_ffff);
      for (int h = 0; h < 4; h++)
         for (int t = 0; t < 2; t++)
            add_row(op_beq, 32'd5, t ? 32'd5 : 32'd6, 31'h600 + n_rows, 12'd4, 0, 0,
                    2'(h), 0, 0, 1, 1, t ? 32'd0 : 32'hffff_ffff);
      // invalid row moves only pc_ff, disabled row moves nothing
      // the invalid row is correctly predicted not taken, so only valid_in keeps
      // pred_correct_out low
      add_row(op_add, 32'd40, 32'd2, 31'h700, 12'd2, 0, 1, 2'b00, 0, 0, 0, 1, 32'd42);
      add_row(op_add, 32'd50, 32'd3, 31'h701, 12'd2, 0, 0, 2'b00, 0, 0, 1, 0, 32'd53);
      for (int n = 0; n < 40; n++)
      begin
         f   = alu_op_t'($urandom % 10);
         a   = $urandom;
         b   = $urandom;
         pc  = 31'($urandom);
         imm = 12'($urandom);
         add_row(f, a, b, pc, imm, 0, 0, 2'($urandom), 0, 0, 1, 1,
                 model_result(f, a, b, pc, imm));
      end
   endtask

   task automatic apply_row(input row_t r);
      op            = r.op;
      a_in          = r.a;
      b_in          = r.b;
      pc_in         = r.pc;
      brimm_in      = r.imm;
      predict_t     = r.pt;
      predict_nt    = r.pnt;
      hist_in       = r.hist;
      flush_upper_x = r.fux;
      flush_lower_r = r.flr;
      valid_in      = r.valid;
      enable        = r.en;
   endtask

   task automatic check_outputs(input row_t r);
      check_value("flush_upper_out", flush_upper_out, r.exp_fu);
      check_value("flush_final_out", flush_final_out, r.exp_ff);
      check_value("flush_path_out", flush_path_out, r.exp_path);
      check_value("pred_correct_out", pred_correct_out, r.exp_pc_ok);
      check_value("misp_out", misp_out, r.exp_misp);
      check_value("ataken_out", ataken_out, r.exp_taken);
      check_value("hist_out", hist_out, r.exp_hist);
   endtask

   task automatic check_registers;
      check_value("result_ff", result_ff, exp_result_ff);
      check_value("pc_ff", pc_ff, exp_pc_ff);
   endtask

   initial
   begin
      int   polls;
      row_t idle;
      idle = '0;
      // a jal would redirect here if valid_in did not gate the flushes
      idle.op = op_jal;
      apply_row(idle);
      exp_result_ff = '0;
      exp_pc_ff     = '0;
      polls = $urandom(37905);
      build_table();
      polls = 0;
      while (rst_n !== 1'b1 && polls < 20*CLK_PERIOD)
      begin
         #1;
         polls++;
      end
      if (rst_n !== 1'b1)
      begin
         $display("timeout: reset was not released within %0d ns", polls);
         fail_run();
      end
      check_registers();
      check_value("flush_upper_out", flush_upper_out, 0);
      check_value("flush_final_out", flush_final_out, 0);
      check_value("pred_correct_out", pred_correct_out, 0);
      for (int i = 0; i < n_rows; i++)
      begin
         wait_cycle();
         check_registers();
         apply_row(rows[i]);
         // combinational outputs settle well before the next edge
         #(CLK_PERIOD - 2);
         check_outputs(rows[i]);
         if (rows[i].en)
         begin
            exp_pc_ff = rows[i].pc;
            if (rows[i].valid)
               exp_result_ff = rows[i].exp_res;
         end
      end
      wait_cycle();
      check_registers();
      $display("Result: PASSED");
      $finish;
   end

endmodule

`default_nettype wire

//--- files.f
+incdir+verilog
verilog/exu_pkg.sv
verilog/exu_alu_datapath.sv
verilog/exu_branch_resolve.sv
verilog/exu_alu_ctl.sv
bench/tb_clock_gen.sv
bench/tb_exu_alu.sv

//--- verilog/exu_alu_ctl.sv
// execute stage top: result and pc registers around the datapath and branch unit
`default_nettype none
`timescale 1ns/1ns
`include "exu_settings.svh"

module exu_alu_ctl (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     enable,
   input  logic                     valid_in,
   input  exu_pkg::alu_op_t         op,
   input  logic [`EXU_DATA_W-1:0]   a_in,
   input  logic [`EXU_DATA_W-1:0]   b_in,
   input  logic [`EXU_PC_W-1:0]     pc_in,
   input  logic [`EXU_BRIMM_W-1:0]  brimm_in,
   input  logic                     predict_t,
   input  logic                     predict_nt,
   input  logic [`EXU_HIST_W-1:0]   hist_in,
   input  logic                     flush_upper_x,
   input  logic                     flush_lower_r,
   output logic [`EXU_DATA_W-1:0]   result_ff,
   output logic [`EXU_PC_W-1:0]     pc_ff,
   output logic                     flush_upper_out,
   output logic                     flush_final_out,
   output logic [`EXU_PC_W-1:0]     flush_path_out,
   output logic                     pred_correct_out,
   output logic                     misp_out,
   output logic                     ataken_out,
   output logic [`EXU_HIST_W-1:0]   hist_out
);

   logic [`EXU_DATA_W-1:0]  result;
   logic                    eq;
   logic                    lt;
   logic [`EXU_PC_W-1:0]    adder_out;
   logic [`EXU_PC_W-1:0]    link_addr;

   exu_alu_datapath u_datapath (
      .op        (op),
      .a_in      (a_in),
      .b_in      (b_in),
      .link_addr (link_addr),
      .result    (result),
      .eq        (eq),
      .lt        (lt),
      .adder_out (adder_out)
   );

   exu_branch_resolve u_branch (
      .op               (op),
      .valid_in         (valid_in),
      .eq               (eq),
      .lt               (lt),
      .pc_in            (pc_in),
      .adder_out        (adder_out),
      .brimm_in         (brimm_in),
      .predict_t        (predict_t),
      .predict_nt       (predict_nt),
      .flush_upper_x    (flush_upper_x),
      .flush_lower_r    (flush_lower_r),
      .hist_in          (hist_in),
      .link_addr        (link_addr),
      .flush_path_out   (flush_path_out),
      .flush_upper_out  (flush_upper_out),
      .flush_final_out  (flush_final_out),
      .pred_correct_out (pred_correct_out),
      .misp_out         (misp_out),
      .ataken_out       (ataken_out),
      .hist_out         (hist_out)
   );

   // result only for valid operations
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         result_ff <= '0;
      else if (enable && valid_in)
         result_ff <= result;
   end

   // every pc passes through here, valid or not
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         pc_ff <= '0;
      else if (enable)
         pc_ff <= pc_in;
   end

endmodule

`default_nettype wire

//--- verilog/exu_alu_datapath.sv
// alu datapath: adder, compare flags, logic unit, shifter and result select
`default_nettype none
`timescale 1ns/1ns
`include "exu_settings.svh"

module exu_alu_datapath (
   input  exu_pkg::alu_op_t         op,
   input  logic [`EXU_DATA_W-1:0]   a_in,
   input  logic [`EXU_DATA_W-1:0]   b_in,
   input  logic [`EXU_PC_W-1:0]     link_addr,   // pc plus 2 or 4 from the branch unit
   output logic [`EXU_DATA_W-1:0]   result,
   output logic                     eq,
   output logic                     lt,
   output logic [`EXU_PC_W-1:0]     adder_out
);

   import exu_pkg::*;

   localparam int DW = `EXU_DATA_W;

   logic              sub_sel;
   logic              unsign;
   logic [DW-1:0]     bm;
   logic [DW-1:0]     aout;
   logic              cout;
   logic              ov;
   logic              neg;
   logic [DW-1:0]     lout;
   logic [`EXU_SHAMT_W-1:0] shift_amount;
   logic [DW-1:0]     shift_mask;
   logic [2*DW-2:0]   shift_extend;
   logic [2*DW-2:0]   shift_long;
   logic [DW-1:0]     sout;

   // compares and branches go through the adder as a subtract
   always_comb
   begin
      sub_sel = 1'b0;
      unsign  = 1'b0;
      case (op)
         op_sub, op_slt, op_beq, op_bne, op_blt, op_bge:
            sub_sel = 1'b1;
         op_sltu, op_bltu, op_bgeu:
         begin
            sub_sel = 1'b1;
            unsign  = 1'b1;
         end
         default:
            sub_sel = 1'b0;
      endcase
   end

   assign bm                = sub_sel ? ~b_in : b_in;
   assign {cout, aout}      = {1'b0, a_in} + {1'b0, bm} + {{DW{1'b0}}, sub_sel};
   assign adder_out         = aout[DW-1:1];

   // signed overflow of the sum
   assign ov  = (~a_in[DW-1] & ~bm[DW-1] &  aout[DW-1]) |
                ( a_in[DW-1] &  bm[DW-1] & ~aout[DW-1]);
   assign neg = aout[DW-1];

   // unsigned less-than is a borrow, i.e. no carry out of a - b
   assign lt  = unsign ? ~cout : (neg ^ ov);
   assign eq  = (a_in == b_in);

   always_comb
   begin
      case (op)
         op_and:  lout = a_in & b_in;
         op_or:   lout = a_in | b_in;
         op_xor:  lout = a_in ^ b_in;
         default: lout = '0;
      endcase
   end

   // left shift by s is a right shift of {a[30:0], a} by 32 - s
   assign shift_amount = (op == op_sll) ? (~b_in[`EXU_SHAMT_W-1:0] + 1'b1) :
                                          b_in[`EXU_SHAMT_W-1:0];

   assign shift_extend[DW-1:0]      = a_in;
   assign shift_extend[2*DW-2:DW]   = (op == op_sra) ? {(DW-1){a_in[DW-1]}} :
                                      (op == op_sll) ? a_in[DW-2:0] :
                                                       '0;

   assign shift_long = shift_extend >> shift_amount;

   // clear the bits that wrap around on a left shift
   assign shift_mask = (op == op_sll) ? ({DW{1'b1}} << b_in[`EXU_SHAMT_W-1:0]) :
                                        {DW{1'b1}};
   assign sout       = shift_long[DW-1:0] & shift_mask;

   always_comb
   begin
      case (op)
         op_add, op_sub:
            result = aout;
         op_and, op_or, op_xor:
            result = lout;
         op_sll, op_srl, op_sra:
            result = sout;
         op_slt, op_sltu:
            result = {{(DW-1){1'b0}}, lt};
         op_jal:
            result = {link_addr, 1'b0};
         op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu:
            result = aout;
         default:
            result = '0;
      endcase
   end

endmodule

`default_nettype wire

//--- verilog/exu_branch_resolve.sv
// branch resolution: target adder, taken decision, mispredict, flushes and history
`default_nettype none
`timescale 1ns/1ns
`include "exu_settings.svh"

module exu_branch_resolve (
   input  exu_pkg::alu_op_t         op,
   input  logic                     valid_in,
   input  logic                     eq,
   input  logic                     lt,
   input  logic [`EXU_PC_W-1:0]     pc_in,
   input  logic [`EXU_PC_W-1:0]     adder_out,
   input  logic [`EXU_BRIMM_W-1:0]  brimm_in,
   input  logic                     predict_t,
   input  logic                     predict_nt,
   input  logic                     flush_upper_x,   // flush from the older stage
   input  logic                     flush_lower_r,   // whole pipeline flush
   input  logic [`EXU_HIST_W-1:0]   hist_in,
   output logic [`EXU_PC_W-1:0]     link_addr,
   output logic [`EXU_PC_W-1:0]     flush_path_out,
   output logic                     flush_upper_out,
   output logic                     flush_final_out,
   output logic                     pred_correct_out,
   output logic                     misp_out,
   output logic                     ataken_out,
   output logic [`EXU_HIST_W-1:0]   hist_out
);

   import exu_pkg::*;

   logic [`EXU_PC_W-1:0]   brimm_ext;
   logic [`EXU_PC_W-1:0]   pcout;
   logic                   is_jal;
   logic                   actual_taken;
   logic                   cond_mispredict;
   logic                   redirect;

   // pc plus offset: opposite path for a branch, link address for jal
   assign brimm_ext = {{(`EXU_PC_W-`EXU_BRIMM_W){brimm_in[`EXU_BRIMM_W-1]}}, brimm_in};
   assign pcout     = pc_in + brimm_ext;
   assign link_addr = pcout;

   assign is_jal    = (op == op_jal);

   always_comb
   begin
      case (op)
         op_beq:           actual_taken = eq;
         op_bne:           actual_taken = ~eq;
         op_blt, op_bltu:  actual_taken = lt;
         op_bge, op_bgeu:  actual_taken = ~lt;
         op_jal:           actual_taken = 1'b1;
         default:          actual_taken = 1'b0;
      endcase
   end

   assign cond_mispredict = (predict_t  & ~actual_taken) |
                            (predict_nt &  actual_taken);

   // jal always redirects, a branch only when it was mispredicted
   assign redirect        = (is_jal | cond_mispredict) & valid_in & ~flush_upper_x;

   assign flush_upper_out = redirect & ~flush_lower_r;
   assign flush_final_out = redirect | flush_lower_r;

   // for jal the adder result is the jump target
   assign flush_path_out  = is_jal ? adder_out : pcout;

   // tells the next-pc logic to keep its own path, never for jal
   assign pred_correct_out = valid_in & ~is_jal &
                             ((predict_nt & ~actual_taken) | (predict_t & actual_taken));

   assign misp_out        = ~flush_upper_x & ~flush_lower_r & cond_mispredict;
   assign ataken_out      = actual_taken;

   // 2-bit history update, indexed by old history and outcome
   always_comb
   begin
      case ({hist_in, actual_taken})
         3'b00_0: hist_out = 2'b01;
         3'b01_0: hist_out = 2'b01;
         3'b10_0: hist_out = 2'b00;
         3'b11_0: hist_out = 2'b10;
         3'b00_1: hist_out = 2'b10;
         3'b01_1: hist_out = 2'b00;
         3'b10_1: hist_out = 2'b11;
         default: hist_out = 2'b11;
      endcase
   end

endmodule

`default_nettype wire

//--- verilog/exu_pkg.sv
// execute stage package with the alu operation enum
`default_nettype none

package exu_pkg;

   // one code per executed operation
   typedef enum logic [4:0] {
      // arithmetic and logic
      op_add,
      op_sub,
      op_and,
      op_or,
      op_xor,
      // shifts
      op_sll,
      op_srl,
      op_sra,
      // set-less-than
      op_slt,
      op_sltu,
      // conditional branches
      op_beq,
      op_bne,
      op_blt,
      op_bge,
      op_bltu,
      op_bgeu,
      // direct jump and link
      op_jal
   } alu_op_t;

endpackage

`default_nettype wire

//--- verilog/exu_settings.svh
// width macros for operands, pc, branch offset, shift amount and branch history
`ifndef EXU_SETTINGS_SVH
`define EXU_SETTINGS_SVH

// operand and result width
`define EXU_DATA_W 32

// halfword pc, bits 31 down to 1
`define EXU_PC_W 31

// branch offset, bits 12 down to 1
`define EXU_BRIMM_W 12

`define EXU_HIST_W 2
`define EXU_SHAMT_W 5

`endif
